// File: verilog/hqm_rob_macros.svh
//--------------------------------------------------------------------
// Reorder buffer sizes
// PP counts, CL window and payload width shared by all blocks
//--------------------------------------------------------------------

`ifndef HQM_ROB_MACROS_SVH
`define HQM_ROB_MACROS_SVH

// Producer ports
`define HQM_ROB_NUM_DIR_PP  4                       // Directed PPs
`define HQM_ROB_NUM_LDB_PP  4                       // Load-balanced PPs
`define HQM_ROB_NUM_PPS     8                       // Directed plus load-balanced
`define HQM_ROB_PPS_WIDTH   3                       // Buffer PP address width

// CL window per PP
`define HQM_ROB_NUM_CLS     4                       // CL slots per PP
`define HQM_ROB_CLS_WIDTH   2                       // CL slot index width

`define HQM_ROB_VPP_WIDTH   2                       // Virtual PP number width
`define HQM_ROB_HCW_WIDTH   32                      // HCW payload width

`endif

// File: verilog/hqm_rob_hcw_pkg.sv
//--------------------------------------------------------------------
// HCW types on the reorder buffer ports
// Input form carries CL fields, output and stored form does not
//--------------------------------------------------------------------

`include "hqm_rob_macros.svh"

package hqm_rob_hcw_pkg;

  // Input HCW as written by the producer port
  typedef struct packed {
    logic [`HQM_ROB_HCW_WIDTH-1:0] payload;         // HCW payload
    logic                          is_ldb;          // Load-balanced port
    logic [`HQM_ROB_VPP_WIDTH-1:0] vpp;             // Virtual PP
    logic [3:0]                    cl;              // Full CL number
    logic [1:0]                    cli;             // HCW index within CL
    logic                          cl_last;         // Last HCW of this CL
    logic                          port_parity;     // Parity over port fields
  } enq_in_t;

  // Output HCW, also the memory word
  typedef struct packed {
    logic [`HQM_ROB_HCW_WIDTH-1:0] payload;
    logic                          is_ldb;
    logic [`HQM_ROB_VPP_WIDTH-1:0] vpp;
    logic                          port_parity;     // Folded with stripped CL bits
  } enq_out_t;

endpackage

// File: verilog/hqm_rob_state_pkg.sv
//--------------------------------------------------------------------
// Reorder buffer state types
// Memory address views, memory request and error report
//--------------------------------------------------------------------

`include "hqm_rob_macros.svh"

package hqm_rob_state_pkg;

  // Memory address, PPs stacked above CLs stacked above HCW index
  typedef union packed {
    logic [`HQM_ROB_PPS_WIDTH+`HQM_ROB_CLS_WIDTH+1:0] idx;   // Flat word index
    struct packed {
      logic [`HQM_ROB_PPS_WIDTH-1:0] pp;
      logic [`HQM_ROB_CLS_WIDTH-1:0] cl;
      logic [1:0]                    cli;
    } f;                                                    // Field view
  } rob_addr_u;

  // Single-port memory request
  typedef struct packed {
    logic                       re;
    logic                       we;
    rob_addr_u                  addr;
    hqm_rob_hcw_pkg::enq_out_t  wdata;
  } mem_req_t;

  typedef logic [2:0] vcnt_t;                       // 0 to 4 HCWs held per CL

  // Error report
  typedef struct packed {
    logic                          strobe;          // Duplicate write pulse
    logic [`HQM_ROB_PPS_WIDTH-1:0] pp;              // Offending PP address
  } rob_err_t;

endpackage

// File: verilog/hqm_rob_pp_map.sv
//--------------------------------------------------------------------
// Reorder buffer PP map
// Finds the buffer PP, CL slot and enable, strips the CL fields
//--------------------------------------------------------------------

`timescale 1ns/10ps

`include "hqm_rob_macros.svh"

module hqm_rob_pp_map (
  input  hqm_rob_hcw_pkg::enq_in_t          enq_in,
  input  logic [`HQM_ROB_NUM_DIR_PP-1:0]    cfg_dir_pp_rob_v,   // Per directed PP enable
  input  logic [`HQM_ROB_NUM_LDB_PP-1:0]    cfg_ldb_pp_rob_v,   // Per load-balanced PP enable
  output logic [`HQM_ROB_PPS_WIDTH-1:0]     pp_addr,
  output logic [`HQM_ROB_CLS_WIDTH-1:0]     cl,
  output logic                              reorder_en,
  output hqm_rob_hcw_pkg::enq_out_t         hcw_out
);

  logic cfg_bit;                                    // Enable bit of this PP
  logic in_window;                                  // CL falls inside the buffer

  // Load-balanced PPs sit above the directed ones
  assign pp_addr = `HQM_ROB_PPS_WIDTH'(enq_in.vpp) +
                   (enq_in.is_ldb ? `HQM_ROB_PPS_WIDTH'(`HQM_ROB_NUM_DIR_PP)
                                  : `HQM_ROB_PPS_WIDTH'(0));

  assign cl = enq_in.cl[`HQM_ROB_CLS_WIDTH-1:0];    // Slot within the window

  assign cfg_bit   = enq_in.is_ldb ? cfg_ldb_pp_rob_v[enq_in.vpp]
                                   : cfg_dir_pp_rob_v[enq_in.vpp];
  assign in_window = (enq_in.cl < 4'(`HQM_ROB_NUM_CLS));

  // CL numbers beyond the window always bypass
  assign reorder_en = cfg_bit & in_window;

  //------------------------------------------------------------------
  // Strip cl_last/cl/cli, keep parity consistent
  //------------------------------------------------------------------
  always_comb begin
    hcw_out.payload     = enq_in.payload;
    hcw_out.is_ldb      = enq_in.is_ldb;
    hcw_out.vpp         = enq_in.vpp;
    hcw_out.port_parity = ^{enq_in.port_parity, enq_in.cl_last, enq_in.cl, enq_in.cli};
  end

endmodule

// File: verilog/hqm_rob_state.sv
//--------------------------------------------------------------------
// Reorder buffer state
// Valid counts per PP and CL, expected CL per PP, cleared by config
//--------------------------------------------------------------------

`timescale 1ns/10ps

`include "hqm_rob_macros.svh"

module hqm_rob_state (
  input  logic                              hqm_gated_clk,
  input  logic                              hqm_gated_rst_n,
  input  logic [`HQM_ROB_NUM_DIR_PP-1:0]    cfg_dir_pp_rob_v,
  input  logic [`HQM_ROB_NUM_LDB_PP-1:0]    cfg_ldb_pp_rob_v,
  input  logic [`HQM_ROB_PPS_WIDTH-1:0]     in_pp,          // Input HCW PP
  input  logic [`HQM_ROB_CLS_WIDTH-1:0]     in_cl,          // Input HCW CL slot
  input  logic [`HQM_ROB_PPS_WIDTH-1:0]     src_pp,         // PP being sourced
  output hqm_rob_state_pkg::vcnt_t          in_cnt,
  output logic [`HQM_ROB_CLS_WIDTH-1:0]     in_exp_cl,
  output logic [`HQM_ROB_CLS_WIDTH-1:0]     src_exp_cl,
  output hqm_rob_state_pkg::vcnt_t          src_cnt,
  output hqm_rob_state_pkg::vcnt_t          src_next_cnt,   // Count of CL after sourced one
  output hqm_rob_state_pkg::vcnt_t          in_next_cnt,    // Count of CL after input one
  input  logic                              inc,            // Input CL count up
  input  logic                              dec,            // Sourced CL count down
  input  logic                              clr_cl,         // Sourced CL emptied
  input  logic                              bump_in,        // Advance input PP pointer
  input  logic                              bump_src        // Advance sourced PP pointer
);

  hqm_rob_state_pkg::vcnt_t [`HQM_ROB_NUM_CLS-1:0] cnt_q [`HQM_ROB_NUM_PPS];
  logic [`HQM_ROB_CLS_WIDTH-1:0]   exp_q [`HQM_ROB_NUM_PPS];  // Next expected CL
  logic [`HQM_ROB_NUM_PPS-1:0]     pp_en;                     // Flat enable per PP
  logic [`HQM_ROB_CLS_WIDTH-1:0]   in_cl_p1;
  logic [`HQM_ROB_CLS_WIDTH-1:0]   src_cl_p1;

  assign pp_en = {cfg_ldb_pp_rob_v, cfg_dir_pp_rob_v};   // Directed PPs at the bottom

  // Slot indices wrap around the window
  assign in_cl_p1   = in_cl + `HQM_ROB_CLS_WIDTH'(1);
  assign src_cl_p1  = src_exp_cl + `HQM_ROB_CLS_WIDTH'(1);

  //------------------------------------------------------------------
  // Read views
  //------------------------------------------------------------------
  assign in_exp_cl    = exp_q[in_pp];
  assign src_exp_cl   = exp_q[src_pp];
  assign in_cnt       = cnt_q[in_pp][in_cl];
  assign in_next_cnt  = cnt_q[in_pp][in_cl_p1];
  assign src_cnt      = cnt_q[src_pp][src_exp_cl];
  assign src_next_cnt = cnt_q[src_pp][src_cl_p1];

  //------------------------------------------------------------------
  // Updates
  //------------------------------------------------------------------
  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (!hqm_gated_rst_n) begin
      for (int p = 0; p < `HQM_ROB_NUM_PPS; p++) begin
        cnt_q[p] <= '0;
        exp_q[p] <= '0;
      end
    end else begin
      if (inc) cnt_q[in_pp][in_cl] <= in_cnt + 3'd1;        // HCW stored
      if (dec) cnt_q[src_pp][src_exp_cl] <= src_cnt - 3'd1; // HCW sourced
      if (clr_cl) cnt_q[src_pp][src_exp_cl] <= '0;          // Last HCW sourced
      if (bump_in) exp_q[in_pp] <= in_cl_p1;
      if (bump_src) exp_q[src_pp] <= src_cl_p1;
      // Disabled PPs lose all saved state, wins over any update
      for (int p = 0; p < `HQM_ROB_NUM_PPS; p++) begin
        if (!pp_en[p]) begin
          cnt_q[p] <= '0;
          exp_q[p] <= '0;
        end
      end
    end
  end

endmodule

// File: verilog/hqm_rob_ctrl.sv
//--------------------------------------------------------------------
// Reorder buffer control
// Bypass, buffer write or sourcing per cycle, stall and error report
//--------------------------------------------------------------------

`timescale 1ns/10ps

`include "hqm_rob_macros.svh"

module hqm_rob_ctrl (
  input  logic                              hqm_gated_clk,
  input  logic                              hqm_gated_rst_n,
  input  logic                              enq_in_v,
  output logic                              enq_in_ready,
  input  hqm_rob_hcw_pkg::enq_in_t          enq_in,
  input  logic                              enq_out_ready,
  output logic                              enq_out_v,
  output hqm_rob_hcw_pkg::enq_out_t         enq_out,
  input  logic [`HQM_ROB_PPS_WIDTH-1:0]     pp_addr,
  input  logic [`HQM_ROB_CLS_WIDTH-1:0]     cl,
  input  logic                              reorder_en,
  input  hqm_rob_hcw_pkg::enq_out_t         hcw_out,        // Stripped input HCW
  output logic [`HQM_ROB_PPS_WIDTH-1:0]     src_pp,
  input  hqm_rob_state_pkg::vcnt_t          in_cnt,
  input  logic [`HQM_ROB_CLS_WIDTH-1:0]     in_exp_cl,
  input  logic [`HQM_ROB_CLS_WIDTH-1:0]     src_exp_cl,
  input  hqm_rob_state_pkg::vcnt_t          src_cnt,
  input  hqm_rob_state_pkg::vcnt_t          src_next_cnt,
  input  hqm_rob_state_pkg::vcnt_t          in_next_cnt,
  output logic                              inc,
  output logic                              dec,
  output logic                              clr_cl,
  output logic                              bump_in,
  output logic                              bump_src,
  output hqm_rob_state_pkg::mem_req_t       mem_req,
  input  hqm_rob_hcw_pkg::enq_out_t         mem_rdata,      // Read data, one cycle after re
  output hqm_rob_state_pkg::rob_err_t       err
);

  logic                            sourcing_q, sourcing_d;  // Buffer drives the output
  logic [`HQM_ROB_PPS_WIDTH-1:0]   src_pp_q, src_pp_d;
  logic [1:0]                      cli_q, cli_d;            // HCW index being sourced
  logic [`HQM_ROB_CLS_WIDTH-1:0]   cl_p1;
  logic [`HQM_ROB_CLS_WIDTH-1:0]   src_cl_p1;
  hqm_rob_state_pkg::rob_addr_u    addr;

  assign src_pp    = src_pp_q;
  assign cl_p1     = cl + `HQM_ROB_CLS_WIDTH'(1);
  assign src_cl_p1 = src_exp_cl + `HQM_ROB_CLS_WIDTH'(1);

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (!hqm_gated_rst_n) begin
      sourcing_q <= 1'b0;
      src_pp_q   <= '0;
      cli_q      <= '0;
    end else begin
      sourcing_q <= sourcing_d;
      src_pp_q   <= src_pp_d;
      cli_q      <= cli_d;
    end
  end

  always_comb begin
    // Defaults, input HCW toward output and write port
    enq_in_ready  = 1'b1;
    enq_out_v     = 1'b0;
    enq_out       = hcw_out;
    {inc, dec, clr_cl, bump_in, bump_src} = '0;
    err.strobe    = 1'b0;
    err.pp        = pp_addr;
    addr.f.pp     = pp_addr;
    addr.f.cl     = cl;
    addr.f.cli    = enq_in.cli;
    mem_req.re    = 1'b0;
    mem_req.we    = 1'b0;
    mem_req.wdata = hcw_out;
    sourcing_d    = sourcing_q;
    src_pp_d      = src_pp_q;
    cli_d         = cli_q;

    //----------------------------------------------------------------
    // Sourcing from the buffer, input stalled
    //----------------------------------------------------------------
    if (sourcing_q) begin
      enq_in_ready = 1'b0;
      enq_out_v    = 1'b1;
      enq_out      = mem_rdata;
      addr.f.pp    = src_pp_q;
      if (enq_out_ready) begin                      // Otherwise hold everything
        if (src_cnt <= 3'd1) begin                  // Last stored HCW of this CL
          clr_cl   = 1'b1;
          bump_src = 1'b1;
          cli_d    = '0;
          if (src_next_cnt == '0) begin
            sourcing_d = 1'b0;                      // No consecutive CL held
          end else begin
            mem_req.re = 1'b1;                      // First HCW of next CL
            addr.f.cl  = src_cl_p1;
            addr.f.cli = 2'd0;
          end
        end else begin
          dec        = 1'b1;
          cli_d      = cli_q + 2'd1;
          mem_req.re = 1'b1;                        // Next HCW in this CL
          addr.f.cl  = src_exp_cl;
          addr.f.cli = cli_q + 2'd1;
        end
      end
    end

    //----------------------------------------------------------------
    // Input HCW
    //----------------------------------------------------------------
    else if (enq_in_v) begin
      if (!reorder_en || (cl == in_exp_cl)) begin   // Bypass
        enq_out_v    = 1'b1;
        enq_in_ready = enq_out_ready;
        if (reorder_en && enq_out_ready && enq_in.cl_last) begin
          bump_in = 1'b1;
          if (in_next_cnt != '0) begin              // Following CL already held
            sourcing_d = 1'b1;
            src_pp_d   = pp_addr;
            cli_d      = '0;
            mem_req.re = 1'b1;
            addr.f.cl  = cl_p1;
            addr.f.cli = 2'd0;
          end
        end
      end else if (in_cnt != {1'b0, enq_in.cli}) begin
        err.strobe = 1'b1;                          // Slot already held, HCW dropped
      end else begin
        inc        = 1'b1;
        mem_req.we = 1'b1;
      end
    end

    mem_req.addr = addr;
  end

endmodule

// File: verilog/hqm_rob_mem.sv
//--------------------------------------------------------------------
// Reorder buffer storage
// Single-port HCW array with registered read data
//--------------------------------------------------------------------

`timescale 1ns/10ps

`include "hqm_rob_macros.svh"

module hqm_rob_mem (
  input  logic                              hqm_gated_clk,
  input  hqm_rob_state_pkg::mem_req_t       mem_req,
  output hqm_rob_hcw_pkg::enq_out_t         rdata
);

  // PPs x CLs x four HCWs
  hqm_rob_hcw_pkg::enq_out_t mem_q [`HQM_ROB_NUM_PPS*`HQM_ROB_NUM_CLS*4];

  always_ff @(posedge hqm_gated_clk) begin
    if (mem_req.we) begin
      mem_q[mem_req.addr.idx] <= mem_req.wdata;
    end
    if (mem_req.re) begin
      rdata <= mem_q[mem_req.addr.idx];             // Held while re is low
    end
  end

endmodule

// File: verilog/hqm_rob.sv
//--------------------------------------------------------------------
// Reorder buffer top level
// Puts producer-port HCW CLs back into order
//--------------------------------------------------------------------

`timescale 1ns/10ps

`include "hqm_rob_macros.svh"

module hqm_rob (
  input  logic                              hqm_gated_clk,
  input  logic                              hqm_gated_rst_n,
  input  logic                              enq_in_v,
  input  hqm_rob_hcw_pkg::enq_in_t          enq_in,
  output logic                              enq_in_ready,
  output logic                              enq_out_v,
  output hqm_rob_hcw_pkg::enq_out_t         enq_out,
  input  logic                              enq_out_ready,
  input  logic [`HQM_ROB_NUM_DIR_PP-1:0]    cfg_dir_pp_rob_v,
  input  logic [`HQM_ROB_NUM_LDB_PP-1:0]    cfg_ldb_pp_rob_v,
  output hqm_rob_state_pkg::rob_err_t       err
);

  logic [`HQM_ROB_PPS_WIDTH-1:0]   pp_addr;
  logic [`HQM_ROB_CLS_WIDTH-1:0]   cl;
  logic                            reorder_en;
  hqm_rob_hcw_pkg::enq_out_t       hcw_out;
  logic [`HQM_ROB_PPS_WIDTH-1:0]   src_pp;
  hqm_rob_state_pkg::vcnt_t        in_cnt, src_cnt, src_next_cnt, in_next_cnt;
  logic [`HQM_ROB_CLS_WIDTH-1:0]   in_exp_cl, src_exp_cl;
  logic                            inc, dec, clr_cl, bump_in, bump_src;
  hqm_rob_state_pkg::mem_req_t     mem_req;
  hqm_rob_hcw_pkg::enq_out_t       mem_rdata;

  hqm_rob_pp_map u_pp_map (
    .enq_in, .cfg_dir_pp_rob_v, .cfg_ldb_pp_rob_v,
    .pp_addr, .cl, .reorder_en, .hcw_out
  );

  hqm_rob_state u_state (
    .hqm_gated_clk, .hqm_gated_rst_n, .cfg_dir_pp_rob_v, .cfg_ldb_pp_rob_v,
    .in_pp (pp_addr), .in_cl (cl), .src_pp,
    .in_cnt, .in_exp_cl, .src_exp_cl, .src_cnt, .src_next_cnt, .in_next_cnt,
    .inc, .dec, .clr_cl, .bump_in, .bump_src
  );

  hqm_rob_ctrl u_ctrl (
    .hqm_gated_clk, .hqm_gated_rst_n,
    .enq_in_v, .enq_in_ready, .enq_in, .enq_out_ready, .enq_out_v, .enq_out,
    .pp_addr, .cl, .reorder_en, .hcw_out, .src_pp,
    .in_cnt, .in_exp_cl, .src_exp_cl, .src_cnt, .src_next_cnt, .in_next_cnt,
    .inc, .dec, .clr_cl, .bump_in, .bump_src,
    .mem_req, .mem_rdata, .err
  );

  hqm_rob_mem u_mem (
    .hqm_gated_clk, .mem_req, .rdata (mem_rdata)
  );

endmodule

// File: tb/hqm_rob_properties.sv
//--------------------------------------------------------------------
// Reorder buffer handshake assertions
// Stall while sourcing, hold under back-pressure, error qualification
//--------------------------------------------------------------------

`timescale 1ns/10ps

module hqm_rob_properties (
  input  logic                              hqm_gated_clk,
  input  logic                              hqm_gated_rst_n,
  input  logic                              enq_in_v,
  input  logic                              enq_in_ready,
  input  logic                              enq_out_v,
  input  logic                              enq_out_ready,
  input  hqm_rob_hcw_pkg::enq_out_t         enq_out,
  input  hqm_rob_state_pkg::rob_err_t       err,
  input  logic                              sourcing    // Buffer owns the output
);

  // Input held off while stored CLs drain
  a_stall: assert property (@(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_n)
    sourcing |-> !enq_in_ready)
    else $error("enq_in_ready high while sourcing");

  a_hold: assert property (@(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_n)
    (enq_out_v && !enq_out_ready) |=> (enq_out_v && $stable(enq_out)))   // Output stalled
    else $error("enq_out changed under back-pressure");

  a_err: assert property (@(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_n)
    err.strobe |-> enq_in_v)
    else $error("err.strobe without an input HCW");

endmodule

bind hqm_rob hqm_rob_properties u_props (
  .hqm_gated_clk, .hqm_gated_rst_n, .enq_in_v, .enq_in_ready,
  .enq_out_v, .enq_out_ready, .enq_out, .err,
  .sourcing (u_ctrl.sourcing_q)
);

// File: tb/hqm_rob_tb.sv
//--------------------------------------------------------------------
// Reorder buffer testbench
// Directed CL traffic per PP, reference model and output compare
//--------------------------------------------------------------------

`timescale 1ns/10ps

`include "hqm_rob_macros.svh"

module hqm_rob_tb;

  typedef hqm_rob_hcw_pkg::enq_in_t      in_q_t[$];
  typedef hqm_rob_hcw_pkg::enq_out_t     out_q_t[$];
  typedef logic [`HQM_ROB_PPS_WIDTH-1:0] pp_q_t[$];

  logic                             hqm_gated_clk = 1'b0;
  logic                             hqm_gated_rst_n;
  logic                             enq_in_v;
  hqm_rob_hcw_pkg::enq_in_t         enq_in;
  logic                             enq_in_ready;
  logic                             enq_out_v;
  hqm_rob_hcw_pkg::enq_out_t        enq_out;
  logic                             enq_out_ready;
  logic [`HQM_ROB_NUM_DIR_PP-1:0]   cfg_dir_pp_rob_v;
  logic [`HQM_ROB_NUM_LDB_PP-1:0]   cfg_ldb_pp_rob_v;
  hqm_rob_state_pkg::rob_err_t      err;

  integer seed = 52;
  in_q_t  stim_q;                                   // HCWs of the running test
  out_q_t exp_out_q;                                // Expected output order
  pp_q_t  exp_err_q;                                // Expected error PPs
  string  test_name = "reset";
  logic   bp_on = 1'b0;                             // Random output stalls
  int     err_cnt = 0;
  int     test_cnt = 0;
  int     test_fail = 0;
  int     out_seen = 0;
  int     sent_total = 0;
  int     cycles = 0;

  always #20 hqm_gated_clk = ~hqm_gated_clk;        // 40 ns period

  hqm_rob u_dut (
    .hqm_gated_clk, .hqm_gated_rst_n, .enq_in_v, .enq_in, .enq_in_ready,
    .enq_out_v, .enq_out, .enq_out_ready, .cfg_dir_pp_rob_v, .cfg_ldb_pp_rob_v, .err
  );

  // Output back-pressure, about one stall in four when enabled
  always @(posedge hqm_gated_clk) begin
    enq_out_ready <= bp_on ? (($random(seed) & 3) != 0) : 1'b1;
  end

  // Watchdog, limit grows with the HCWs handed to the DUT
  always @(posedge hqm_gated_clk) begin
    cycles++;
    if (cycles > sent_total * 10 + 400) begin
      $display("Timeout: the DUT made no progress within %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check(input string name, input logic [63:0] expv, input logic [63:0] actv);
    if (expv !== actv) begin
      $display("FAILED %s expected %h actual %h", name, expv, actv);
      err_cnt++;
    end
  endtask

  //------------------------------------------------------------------
  // Compare, sampled at the falling edge where all handshakes are settled
  //------------------------------------------------------------------
  always @(negedge hqm_gated_clk) begin
    if (hqm_gated_rst_n && enq_out_v && enq_out_ready) begin
      out_seen++;
      if (exp_out_q.size() == 0) begin
        $display("Test %s: unexpected HCW %h at the output", test_name, enq_out);
        err_cnt++;
      end else begin
        check(test_name, 64'(exp_out_q.pop_front()), 64'(enq_out));
      end
    end
    if (hqm_gated_rst_n && err.strobe && enq_in_v && enq_in_ready) begin
      if (exp_err_q.size() == 0) begin
        $display("Test %s: unexpected error pulse for PP %0d", test_name, err.pp);
        err_cnt++;
      end else begin
        check(test_name, 64'(exp_err_q.pop_front()), 64'(err.pp));
      end
    end
  end

  // Expected output and error PPs from the window rules, starting from empty state
  function automatic void ref_model(input logic [3:0] dir_en, input logic [3:0] ldb_en,
                                    input in_q_t hcws, output out_q_t outs,
                                    output pp_q_t errs);
    hqm_rob_hcw_pkg::enq_out_t store [`HQM_ROB_NUM_PPS][`HQM_ROB_NUM_CLS][4];
    int                        cnt [`HQM_ROB_NUM_PPS][`HQM_ROB_NUM_CLS];
    int                        exp_cl [`HQM_ROB_NUM_PPS];
    hqm_rob_hcw_pkg::enq_in_t  h;
    hqm_rob_hcw_pkg::enq_out_t o;
    int                        i, k, pp, slot;
    logic                      en;
    outs = {};
    errs = {};
    for (pp = 0; pp < `HQM_ROB_NUM_PPS; pp++) begin
      exp_cl[pp] = 0;
      for (k = 0; k < `HQM_ROB_NUM_CLS; k++) cnt[pp][k] = 0;
    end
    for (i = 0; i < hcws.size(); i++) begin
      h = hcws[i];
      o.payload     = h.payload;
      o.is_ldb      = h.is_ldb;
      o.vpp         = h.vpp;
      o.port_parity = h.port_parity ^ h.cl_last ^ (^h.cl) ^ (^h.cli);
      pp   = h.is_ldb ? `HQM_ROB_NUM_DIR_PP + int'(h.vpp) : int'(h.vpp);
      slot = int'(h.cl) % `HQM_ROB_NUM_CLS;
      en   = (h.is_ldb ? ldb_en[h.vpp] : dir_en[h.vpp]) && (int'(h.cl) < `HQM_ROB_NUM_CLS);
      if (!en || slot == exp_cl[pp]) begin
        outs.push_back(o);                          // Straight to the output
        if (en && h.cl_last) begin
          exp_cl[pp] = (exp_cl[pp] + 1) % `HQM_ROB_NUM_CLS;
          while (cnt[pp][exp_cl[pp]] != 0) begin    // Drain consecutive held CLs
            for (k = 0; k < cnt[pp][exp_cl[pp]]; k++) outs.push_back(store[pp][exp_cl[pp]][k]);
            cnt[pp][exp_cl[pp]] = 0;
            exp_cl[pp] = (exp_cl[pp] + 1) % `HQM_ROB_NUM_CLS;
          end
        end
      end else if (cnt[pp][slot] != int'(h.cli)) begin
        errs.push_back(3'(pp));                     // Slot already held, HCW lost
      end else begin
        store[pp][slot][h.cli] = o;
        cnt[pp][slot]++;
      end
    end
  endfunction

  task automatic add_cl(input logic is_ldb, input logic [1:0] vpp, input logic [3:0] cl,
                        input int n);
    hqm_rob_hcw_pkg::enq_in_t h;
    int                       k;
    for (k = 0; k < n; k++) begin
      h.payload     = $random(seed);
      h.is_ldb      = is_ldb;
      h.vpp         = vpp;
      h.cl          = cl;
      h.cli         = 2'(k);
      h.cl_last     = (k == n - 1);
      h.port_parity = 1'($random(seed));
      stim_q.push_back(h);
    end
  endtask

  task automatic send_all();
    int i;
    for (i = 0; i < stim_q.size(); i++) begin
      @(posedge hqm_gated_clk);
      enq_in_v <= 1'b1;
      enq_in   <= stim_q[i];
      @(negedge hqm_gated_clk);
      while (!enq_in_ready) @(negedge hqm_gated_clk);   // Taken at the next rising edge
    end
    @(posedge hqm_gated_clk);
    enq_in_v <= 1'b0;
  endtask

  task automatic run_test(input string name, input logic [3:0] dir_en,
                          input logic [3:0] ldb_en, input logic bp);
    int errs_before;
    int wait_cyc;
    errs_before = err_cnt;
    test_name   = name;
    out_seen    = 0;
    ref_model(dir_en, ldb_en, stim_q, exp_out_q, exp_err_q);
    sent_total += stim_q.size();
    @(posedge hqm_gated_clk);
    cfg_dir_pp_rob_v <= '0;                         // Clears all saved PP state
    cfg_ldb_pp_rob_v <= '0;
    repeat (3) @(posedge hqm_gated_clk);
    cfg_dir_pp_rob_v <= dir_en;
    cfg_ldb_pp_rob_v <= ldb_en;
    bp_on            <= bp;
    send_all();
    wait_cyc = 0;
    while ((exp_out_q.size() != 0 || exp_err_q.size() != 0) && wait_cyc < 200) begin
      @(posedge hqm_gated_clk);
      wait_cyc++;
    end
    repeat (6) @(posedge hqm_gated_clk);            // Room for stray late outputs
    bp_on <= 1'b0;
    if (exp_out_q.size() != 0 || exp_err_q.size() != 0) begin
      $display("Test %s: %0d HCWs and %0d error pulses never showed up", name,
               exp_out_q.size(), exp_err_q.size());
      err_cnt++;
      exp_out_q.delete();
      exp_err_q.delete();
    end
    test_cnt++;
    if (err_cnt != errs_before) test_fail++;
    $display("Test %s: %0d HCWs out, %0d errors", name, out_seen, err_cnt - errs_before);
    stim_q.delete();
  endtask

  initial begin
    hqm_gated_rst_n  = 1'b0;
    enq_in_v         = 1'b0;
    enq_in           = '0;
    enq_out_ready    = 1'b1;
    cfg_dir_pp_rob_v = '0;
    cfg_ldb_pp_rob_v = '0;
    repeat (3) @(posedge hqm_gated_clk);
    hqm_gated_rst_n <= 1'b1;
    add_cl(1'b0, 2'd2, 4'd1, 4);                    // PP without reordering
    add_cl(1'b0, 2'd0, 4'd5, 2);                    // CL beyond the window
    add_cl(1'b1, 2'd1, 4'd3, 3);
    run_test("pass_thru", 4'b0001, 4'b0000, 1'b0);
    add_cl(1'b1, 2'd2, 4'd2, 4);
    add_cl(1'b1, 2'd2, 4'd1, 3);                    // Short CL
    add_cl(1'b1, 2'd2, 4'd0, 4);
    run_test("reorder", 4'b0000, 4'b0100, 1'b0);
    add_cl(1'b0, 2'd0, 4'd1, 2);
    add_cl(1'b1, 2'd0, 4'd2, 4);
    add_cl(1'b0, 2'd1, 4'd1, 4);
    add_cl(1'b1, 2'd0, 4'd1, 1);
    add_cl(1'b0, 2'd0, 4'd0, 3);
    add_cl(1'b0, 2'd1, 4'd0, 2);
    add_cl(1'b1, 2'd0, 4'd0, 4);
    add_cl(1'b0, 2'd0, 4'd3, 2);
    add_cl(1'b0, 2'd0, 4'd2, 4);
    run_test("backpressure", 4'b0011, 4'b0001, 1'b1);
    add_cl(1'b0, 2'd1, 4'd1, 2);
    add_cl(1'b0, 2'd1, 4'd1, 1);                    // Same slot again
    add_cl(1'b0, 2'd1, 4'd0, 1);
    run_test("duplicate", 4'b0010, 4'b0000, 1'b0);
    add_cl(1'b1, 2'd3, 4'd2, 4);
    add_cl(1'b1, 2'd3, 4'd1, 2);
    run_test("cfg_store", 4'b0000, 4'b1000, 1'b0);
    add_cl(1'b1, 2'd3, 4'd0, 4);                    // Held CLs must be gone
    run_test("cfg_clear", 4'b0000, 4'b1000, 1'b0);
    $display("Summary: %0d tests, %0d with errors, %0d HCWs sent, %0d errors in all",
             test_cnt, test_fail, sent_total, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+verilog
verilog/hqm_rob_hcw_pkg.sv
verilog/hqm_rob_state_pkg.sv
verilog/hqm_rob_pp_map.sv
verilog/hqm_rob_state.sv
verilog/hqm_rob_ctrl.sv
verilog/hqm_rob_mem.sv
verilog/hqm_rob.sv
tb/hqm_rob_properties.sv
tb/hqm_rob_tb.sv

// File: Makefile
# Verilator build and run of the reorder buffer testbench

SRCS := $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vhqm_rob_tb: src.f $(SRCS)
	verilator --binary --timing --assert --top-module hqm_rob_tb -f src.f -o Vhqm_rob_tb

run: obj_dir/Vhqm_rob_tb
	./obj_dir/Vhqm_rob_tb | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
